/* source/dma_soc_config.svh */
// DMA subsystem sizes and address map
`ifndef DMA_SOC_CONFIG_SVH
`define DMA_SOC_CONFIG_SVH

`define DATA_W      32
`define ADDR_W      32
`define RAM_DEPTH   256
`define IDX_W       8
`define LEN_W       9
`define REG_OFS_W   5

// Region codes in address bits 15:12
`define REGION_REG    4'd0
`define REGION_RAM_A  4'd1
`define REGION_RAM_B  4'd2

// DMA register byte offsets
`define REG_SRC     5'h00
`define REG_DST     5'h04
`define REG_LEN     5'h08
`define REG_CTRL    5'h0C
`define REG_STATUS  5'h10

`endif

/* source/dma_soc_pkg.sv */
// DMA subsystem shared types
`default_nettype none
`include "dma_soc_config.svh"

package dma_soc_pkg;

    // Field view of a host address
    typedef struct packed {
        logic [`ADDR_W-17:0] unused;
        logic [3:0]          region;
        logic [9-`IDX_W:0]   rsvd;
        logic [`IDX_W-1:0]   idx;
        logic [1:0]          byte_ofs;
    } sys_addr_f_t;

    typedef union packed {
        logic [`ADDR_W-1:0] raw;
        sys_addr_f_t        f;
    } sys_addr_u;

    typedef struct packed {
        logic               we;
        logic [`IDX_W-1:0]  waddr;
        logic [`DATA_W-1:0] wdata;
        logic               re;
        logic [`IDX_W-1:0]  raddr;
    } ram_req_t;

    typedef struct packed {
        sys_addr_u         src;
        sys_addr_u         dst;
        logic [`LEN_W-1:0] len;
        logic              start;
    } dma_cfg_t;

    // Busy sits in bit 0 of STATUS
    typedef struct packed {
        logic err;
        logic done;
        logic busy;
    } dma_status_t;

endpackage

`default_nettype wire

/* source/periph_ram.sv */
// Peripheral word RAM
`timescale 1ns/1ps
`default_nettype none
`include "dma_soc_config.svh"

module periph_ram
    import dma_soc_pkg::*;
(
    input  logic               clk,
    input  ram_req_t           req_i,
    output logic [`DATA_W-1:0] rdata_o
);

    logic [`DATA_W-1:0] mem [0:`RAM_DEPTH-1];
    logic [`DATA_W-1:0] rdata_q;

    always_ff @(posedge clk) begin
        if (req_i.we) begin
            mem[req_i.waddr] <= req_i.wdata;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (req_i.re) begin
            rdata_q <= mem[req_i.raddr];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* source/dma_reg_decode.sv */
// Host port decode and DMA registers
`timescale 1ns/1ps
`default_nettype none
`include "dma_soc_config.svh"

module dma_reg_decode
    import dma_soc_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               wr_en_i,
    input  logic               rd_en_i,
    input  sys_addr_u          addr_i,
    input  logic [`DATA_W-1:0] wdata_i,
    input  dma_status_t        status_i,
    input  logic [`DATA_W-1:0] ram_a_rdata_i,
    input  logic [`DATA_W-1:0] ram_b_rdata_i,
    output dma_cfg_t           cfg_o,
    output logic               clear_o,
    output logic               ie_o,
    output ram_req_t           host_a_o,
    output ram_req_t           host_b_o,
    output logic [`DATA_W-1:0] rdata_o
);

    logic [`REG_OFS_W-1:0] reg_ofs;
    logic                  sel_reg;
    logic                  sel_a;
    logic                  sel_b;
    logic                  ctrl_wr;
    logic [`DATA_W-1:0]    reg_rdata;
    logic [`DATA_W-1:0]    ram_rdata;

    sys_addr_u             src_q;
    sys_addr_u             dst_q;
    logic [`LEN_W-1:0]     len_q;
    logic                  ie_q;
    logic                  start_q;
    logic                  clear_q;
    logic                  rd_ram_q;
    logic                  rd_b_q;
    logic [`DATA_W-1:0]    rdata_q;

    // Strip the region offset, only the low bits pick a register
    assign reg_ofs = addr_i.raw[`REG_OFS_W-1:0];
    assign sel_reg = (addr_i.f.region == `REGION_REG);
    // RAMs belong to the engine while a copy runs
    assign sel_a   = (addr_i.f.region == `REGION_RAM_A) && !status_i.busy;
    assign sel_b   = (addr_i.f.region == `REGION_RAM_B) && !status_i.busy;
    assign ctrl_wr = wr_en_i && sel_reg && (reg_ofs == `REG_CTRL);

    always_comb begin
        case (reg_ofs)
            `REG_SRC:    reg_rdata = src_q.raw;
            `REG_DST:    reg_rdata = dst_q.raw;
            `REG_LEN:    reg_rdata = {{(`DATA_W-`LEN_W){1'b0}}, len_q};
            `REG_CTRL:   reg_rdata = {{(`DATA_W-2){1'b0}}, ie_q, 1'b0};
            `REG_STATUS: reg_rdata = {{(`DATA_W-3){1'b0}}, status_i};
            default:     reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            src_q   <= '0;
            dst_q   <= '0;
            len_q   <= '0;
            ie_q    <= 1'b0;
            start_q <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            start_q <= ctrl_wr && wdata_i[0];
            // Any CTRL write acknowledges done and err
            clear_q <= ctrl_wr;
            if (wr_en_i && sel_reg) begin
                case (reg_ofs)
                    `REG_SRC:  src_q.raw <= wdata_i;
                    `REG_DST:  dst_q.raw <= wdata_i;
                    `REG_LEN:  len_q     <= wdata_i[`LEN_W-1:0];
                    `REG_CTRL: ie_q      <= wdata_i[1];
                    default:   ;
                endcase
            end
        end
    end

    assign ram_rdata = rd_b_q ? ram_b_rdata_i : ram_a_rdata_i;

    // Register data is captured at the read edge, RAM data one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_ram_q <= 1'b0;
            rd_b_q   <= 1'b0;
            rdata_q  <= '0;
        end else if (rd_en_i) begin
            rd_ram_q <= sel_a || sel_b;
            rd_b_q   <= sel_b;
            rdata_q  <= sel_reg ? reg_rdata : '0;
        end else if (rd_ram_q) begin
            rd_ram_q <= 1'b0;
            rdata_q  <= ram_rdata;
        end
    end

    assign rdata_o = rd_ram_q ? ram_rdata : rdata_q;

    assign cfg_o   = '{src: src_q, dst: dst_q, len: len_q, start: start_q};
    assign clear_o = clear_q;
    assign ie_o    = ie_q;

    assign host_a_o = '{
        we:    wr_en_i && sel_a,
        waddr: addr_i.f.idx,
        wdata: wdata_i,
        re:    rd_en_i && sel_a,
        raddr: addr_i.f.idx
    };

    assign host_b_o = '{
        we:    wr_en_i && sel_b,
        waddr: addr_i.f.idx,
        wdata: wdata_i,
        re:    rd_en_i && sel_b,
        raddr: addr_i.f.idx
    };

endmodule

`default_nettype wire

/* source/dma_copy_engine.sv */
// Block copy engine
`timescale 1ns/1ps
`default_nettype none
`include "dma_soc_config.svh"

module dma_copy_engine
    import dma_soc_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  dma_cfg_t           cfg_i,
    input  logic [`DATA_W-1:0] ram_a_rdata_i,
    input  logic [`DATA_W-1:0] ram_b_rdata_i,
    output logic               busy_o,
    output logic               finish_o,
    output logic               finish_err_o,
    output ram_req_t           eng_a_o,
    output ram_req_t           eng_b_o
);

    logic                src_ok;
    logic                dst_ok;
    logic [`LEN_W:0]     src_end;
    logic [`LEN_W:0]     dst_end;
    logic                range_ok;
    logic                rd_go;
    logic                wr_go;
    logic [`DATA_W-1:0]  rd_data;

    logic                busy_q;
    logic                finish_q;
    logic                err_q;
    logic                src_b_q;
    logic                dst_b_q;
    logic [`LEN_W-1:0]   rd_left_q;
    logic                wr_vld_q;
    logic [`IDX_W-1:0]   rd_ptr_q;
    logic [`IDX_W-1:0]   wr_ptr_q;

    assign src_ok = (cfg_i.src.f.region == `REGION_RAM_A) ||
                    (cfg_i.src.f.region == `REGION_RAM_B);
    assign dst_ok = (cfg_i.dst.f.region == `REGION_RAM_A) ||
                    (cfg_i.dst.f.region == `REGION_RAM_B);

    // One past the last word of each block
    assign src_end = (`LEN_W+1)'(cfg_i.src.f.idx) + (`LEN_W+1)'(cfg_i.len);
    assign dst_end = (`LEN_W+1)'(cfg_i.dst.f.idx) + (`LEN_W+1)'(cfg_i.len);

    assign range_ok = src_ok && dst_ok &&
                      (src_end <= (`LEN_W+1)'(`RAM_DEPTH)) &&
                      (dst_end <= (`LEN_W+1)'(`RAM_DEPTH));

    assign rd_go = busy_q && (rd_left_q != '0);
    assign wr_go = busy_q && wr_vld_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            finish_q  <= 1'b0;
            err_q     <= 1'b0;
            src_b_q   <= 1'b0;
            dst_b_q   <= 1'b0;
            rd_left_q <= '0;
            wr_vld_q  <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            wr_vld_q <= rd_go;
            if (busy_q) begin
                if (rd_go) begin
                    rd_left_q <= rd_left_q - (`LEN_W)'(1);
                end
                // No reads left means the last word is written now
                if (rd_left_q == '0) begin
                    busy_q   <= 1'b0;
                    finish_q <= 1'b1;
                    err_q    <= 1'b0;
                end
            end else if (cfg_i.start) begin
                if (!range_ok) begin
                    finish_q <= 1'b1;
                    err_q    <= 1'b1;
                end else if (cfg_i.len == '0) begin
                    finish_q <= 1'b1;
                    err_q    <= 1'b0;
                end else begin
                    busy_q    <= 1'b1;
                    rd_left_q <= cfg_i.len;
                    src_b_q   <= (cfg_i.src.f.region == `REGION_RAM_B);
                    dst_b_q   <= (cfg_i.dst.f.region == `REGION_RAM_B);
                end
            end
        end
    end

    // Write pointer trails the read pointer by one word
    always_ff @(posedge clk) begin
        if (!busy_q) begin
            rd_ptr_q <= cfg_i.src.f.idx;
            wr_ptr_q <= cfg_i.dst.f.idx;
        end else begin
            if (rd_go) begin
                rd_ptr_q <= rd_ptr_q + (`IDX_W)'(1);
            end
            if (wr_go) begin
                wr_ptr_q <= wr_ptr_q + (`IDX_W)'(1);
            end
        end
    end

    assign rd_data = src_b_q ? ram_b_rdata_i : ram_a_rdata_i;

    assign eng_a_o = '{
        we:    wr_go && !dst_b_q,
        waddr: wr_ptr_q,
        wdata: rd_data,
        re:    rd_go && !src_b_q,
        raddr: rd_ptr_q
    };

    assign eng_b_o = '{
        we:    wr_go && dst_b_q,
        waddr: wr_ptr_q,
        wdata: rd_data,
        re:    rd_go && src_b_q,
        raddr: rd_ptr_q
    };

    assign busy_o       = busy_q;
    assign finish_o     = finish_q;
    assign finish_err_o = err_q;

endmodule

`default_nettype wire

/* source/dma_done_irq.sv */
// DMA status flags and done interrupt
`timescale 1ns/1ps
`default_nettype none

module dma_done_irq
    import dma_soc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        busy_i,
    input  logic        finish_i,
    input  logic        finish_err_i,
    input  logic        clear_i,
    input  logic        ie_i,
    output dma_status_t status_o,
    output logic        int_o
);

    logic done_q;
    logic err_q;

    // Flags hold until the host acknowledges through CTRL
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end else if (finish_i) begin
            done_q <= 1'b1;
            err_q  <= err_q || finish_err_i;
        end else if (clear_i) begin
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end
    end

    assign status_o = '{err: err_q, done: done_q, busy: busy_i};
    assign int_o    = done_q && ie_i;

endmodule

`default_nettype wire

/* source/dma_soc_top.sv */
// DMA copy subsystem top
`timescale 1ns/1ps
`default_nettype none
`include "dma_soc_config.svh"

module dma_soc_top
    import dma_soc_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               wr_en_i,
    input  logic               rd_en_i,
    input  logic [`ADDR_W-1:0] addr_i,
    input  logic [`DATA_W-1:0] wdata_i,
    output logic [`DATA_W-1:0] rdata_o,
    output logic               int_o
);

    dma_cfg_t           cfg;
    dma_status_t        status;
    logic               clear;
    logic               ie;
    logic               busy;
    logic               finish;
    logic               finish_err;
    ram_req_t           host_a;
    ram_req_t           host_b;
    ram_req_t           eng_a;
    ram_req_t           eng_b;
    ram_req_t           ram_a_req;
    ram_req_t           ram_b_req;
    logic [`DATA_W-1:0] ram_a_rdata;
    logic [`DATA_W-1:0] ram_b_rdata;

    dma_reg_decode reg_decode_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wr_en_i        (wr_en_i),
        .rd_en_i        (rd_en_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .status_i       (status),
        .ram_a_rdata_i  (ram_a_rdata),
        .ram_b_rdata_i  (ram_b_rdata),
        .cfg_o          (cfg),
        .clear_o        (clear),
        .ie_o           (ie),
        .host_a_o       (host_a),
        .host_b_o       (host_b),
        .rdata_o        (rdata_o)
    );

    dma_copy_engine copy_engine_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .cfg_i          (cfg),
        .ram_a_rdata_i  (ram_a_rdata),
        .ram_b_rdata_i  (ram_b_rdata),
        .busy_o         (busy),
        .finish_o       (finish),
        .finish_err_o   (finish_err),
        .eng_a_o        (eng_a),
        .eng_b_o        (eng_b)
    );

    dma_done_irq done_irq_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .busy_i         (busy),
        .finish_i       (finish),
        .finish_err_i   (finish_err),
        .clear_i        (clear),
        .ie_i           (ie),
        .status_o       (status),
        .int_o          (int_o)
    );

    // Engine owns both RAM ports for the whole copy
    assign ram_a_req = busy ? eng_a : host_a;
    assign ram_b_req = busy ? eng_b : host_b;

    periph_ram ram_a (
        .clk            (clk),
        .req_i          (ram_a_req),
        .rdata_o        (ram_a_rdata)
    );

    periph_ram ram_b (
        .clk            (clk),
        .req_i          (ram_b_req),
        .rdata_o        (ram_b_rdata)
    );

endmodule

`default_nettype wire

/* bench/dma_soc_tb.sv */
// DMA copy subsystem testbench
`timescale 1ns/1ps
`default_nettype none
`include "dma_soc_config.svh"

module dma_soc_tb;

    localparam int CYCLE_LIMIT = 4000;
    localparam int POLL_LIMIT  = 100;

    logic        clk;
    logic        rst_n;
    logic        wr_en;
    logic        rd_en;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        int_sig;

    // Expected RAM contents, indexed by region code and word index
    logic [31:0] model_mem [0:2][0:255];
    integer      seed;
    int          cycle_cnt = 0;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;
    string       test_name;

    dma_soc_top dma_soc_top_inst (
        .clk     (clk),
        .rst_n_i (rst_n),
        .wr_en_i (wr_en),
        .rd_en_i (rd_en),
        .addr_i  (addr),
        .wdata_i (wdata),
        .rdata_o (rdata),
        .int_o   (int_sig)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles in test %s", CYCLE_LIMIT, test_name);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Region in bits 15:12, word index in bits 9:2
    function automatic logic [31:0] ram_addr(input int region, input int idx);
        return 32'((region << 12) | (idx << 2));
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR %s: %s expected 0x%08h actual 0x%08h", test_name, what, exp, act);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, test_errs);
            tests_failed++;
        end
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        @(negedge clk);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // Data is valid on the cycle after the read edge
    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        @(negedge clk);
        rd_en = 1'b1;
        addr  = a;
        @(negedge clk);
        d     = rdata;
        rd_en = 1'b0;
    endtask

    task automatic fill_ram(input int region, input int first, input int count);
        logic [31:0] value;
        for (int i = first; i < first + count; i++) begin
            value = $random(seed);
            bus_write(ram_addr(region, i), value);
            model_mem[region][i] = value;
        end
    endtask

    task automatic check_ram(input int region, input int first, input int count);
        logic [31:0] value;
        string       what;
        for (int i = first; i < first + count; i++) begin
            bus_read(ram_addr(region, i), value);
            if (value !== model_mem[region][i]) begin
                what = $sformatf("RAM %0d word %0d", region, i);
                report_mismatch(what, model_mem[region][i], value);
            end
        end
    endtask

    task automatic copy_model(input int sr, input int si, input int dr, input int di,
                              input int len);
        for (int k = 0; k < len; k++) begin
            model_mem[dr][di + k] = model_mem[sr][si + k];
        end
    endtask

    task automatic run_copy(input logic [31:0] src, input logic [31:0] dst, input int len,
                            input logic [31:0] ctrl, output logic [31:0] status);
        int polls;
        bus_write(32'(`REG_SRC), src);
        bus_write(32'(`REG_DST), dst);
        bus_write(32'(`REG_LEN), 32'(len));
        bus_write(32'(`REG_CTRL), ctrl);
        // Let the start pulse clear the old done flag
        repeat (2) @(negedge clk);
        polls  = 0;
        status = '0;
        while (status[1] == 1'b0 && polls < POLL_LIMIT) begin
            bus_read(32'(`REG_STATUS), status);
            polls++;
        end
        if (status[1] == 1'b0) begin
            $display("%s: DMA did not report done after %0d STATUS polls",
                     test_name, POLL_LIMIT);
            test_errs++;
        end
    endtask

    task automatic test_reset_regs();
        logic [31:0] value;
        logic [31:0] src_val;
        logic [31:0] dst_val;
        logic [31:0] len_val;
        start_test("reset_regs");
        bus_read(32'(`REG_STATUS), value);
        if (value !== 32'h0) report_mismatch("STATUS after reset", 32'h0, value);
        if (int_sig !== 1'b0) report_mismatch("int_o after reset", 32'h0, {31'h0, int_sig});
        src_val = $random(seed);
        dst_val = $random(seed);
        len_val = $random(seed);
        bus_write(32'(`REG_SRC), src_val);
        bus_write(32'(`REG_DST), dst_val);
        bus_write(32'(`REG_LEN), len_val);
        bus_read(32'(`REG_SRC), value);
        if (value !== src_val) report_mismatch("SRC readback", src_val, value);
        bus_read(32'(`REG_DST), value);
        if (value !== dst_val) report_mismatch("DST readback", dst_val, value);
        // LEN keeps 9 bits
        bus_read(32'(`REG_LEN), value);
        if (value !== (len_val & 32'h1FF)) begin
            report_mismatch("LEN readback", len_val & 32'h1FF, value);
        end
        finish_test();
    endtask

    task automatic test_host_ram();
        start_test("host_ram");
        for (int i = 0; i < 8; i++) begin
            fill_ram(1, (i * 37 + 3) % 256, 1);
            fill_ram(2, (i * 53 + 7) % 256, 1);
        end
        for (int i = 0; i < 8; i++) begin
            check_ram(1, (i * 37 + 3) % 256, 1);
            check_ram(2, (i * 53 + 7) % 256, 1);
        end
        finish_test();
    endtask

    task automatic test_copy_a_to_b();
        logic [31:0] status;
        start_test("copy_a_to_b");
        fill_ram(1, 10, 16);
        fill_ram(2, 38, 20);
        run_copy(ram_addr(1, 10), ram_addr(2, 40), 16, 32'h1, status);
        copy_model(1, 10, 2, 40, 16);
        if (status !== 32'h2) report_mismatch("STATUS after copy", 32'h2, status);
        check_ram(2, 38, 20);
        finish_test();
    endtask

    task automatic test_copy_in_a_irq();
        logic [31:0] status;
        start_test("copy_in_a_irq");
        fill_ram(1, 100, 8);
        fill_ram(1, 149, 10);
        run_copy(ram_addr(1, 100), ram_addr(1, 150), 8, 32'h3, status);
        copy_model(1, 100, 1, 150, 8);
        if (status !== 32'h2) report_mismatch("STATUS after copy", 32'h2, status);
        if (int_sig !== 1'b1) report_mismatch("int_o after done", 32'h1, {31'h0, int_sig});
        check_ram(1, 149, 10);
        // Acknowledge with ie kept and no start
        bus_write(32'(`REG_CTRL), 32'h2);
        repeat (2) @(negedge clk);
        if (int_sig !== 1'b0) report_mismatch("int_o after clear", 32'h0, {31'h0, int_sig});
        bus_read(32'(`REG_STATUS), status);
        if (status !== 32'h0) report_mismatch("STATUS after clear", 32'h0, status);
        finish_test();
    endtask

    task automatic test_rejected_ranges();
        logic [31:0] status;
        start_test("rejected_ranges");
        fill_ram(1, 0, 4);
        fill_ram(1, 20, 4);
        fill_ram(2, 20, 4);
        run_copy(ram_addr(1, 0), ram_addr(3, 20), 4, 32'h1, status);
        if (status !== 32'h6) report_mismatch("STATUS for region 3", 32'h6, status);
        check_ram(1, 20, 4);
        check_ram(2, 20, 4);
        // 250 + 8 runs past the end of RAM A
        fill_ram(1, 250, 6);
        fill_ram(2, 0, 8);
        run_copy(ram_addr(1, 250), ram_addr(2, 0), 8, 32'h1, status);
        if (status !== 32'h6) report_mismatch("STATUS for overrun", 32'h6, status);
        check_ram(2, 0, 8);
        finish_test();
    endtask

    task automatic test_zero_length();
        logic [31:0] status;
        start_test("zero_length");
        fill_ram(1, 30, 4);
        fill_ram(2, 30, 4);
        run_copy(ram_addr(1, 30), ram_addr(2, 30), 0, 32'h1, status);
        if (status !== 32'h2) report_mismatch("STATUS for zero length", 32'h2, status);
        check_ram(1, 30, 4);
        check_ram(2, 30, 4);
        finish_test();
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        rd_en        = 1'b0;
        addr         = '0;
        wdata        = '0;
        seed         = 66;
        test_errs    = 0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        test_reset_regs();
        test_host_ram();
        test_copy_a_to_b();
        test_copy_in_a_irq();
        test_rejected_ranges();
        test_zero_length();

        $display("Tests run: %0d, failed: %0d, check errors: %0d",
                 tests_run, tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dma_soc.f */
+incdir+source
source/dma_soc_pkg.sv
source/periph_ram.sv
source/dma_reg_decode.sv
source/dma_copy_engine.sv
source/dma_done_irq.sv
source/dma_soc_top.sv
bench/dma_soc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the DMA copy testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dma_soc_tb -f dma_soc.f \
    --Mdir obj_dir -o dma_soc_sim > build.log 2>&1 \
    && ./obj_dir/dma_soc_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log \
    && { echo "Testbench reported failure, see sim.log"; exit 1; } \
    || { echo "No failure reported, see sim.log"; exit 0; }
